//--- common/fe_cfg.svh
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// fetch buffer entries, keep a power of two
`define FE_IFB_DEPTH 8

// log2 of FE_IFB_DEPTH
`define FE_IFB_PTR_W 3

// first fetch address after reset
`define FE_PC_RESET 64'h1000

`endif

//--- common/fe_types_pkg.sv
`include "fe_cfg.svh"

package fe_types_pkg;

	// instruction address
	typedef logic [63:0] pc_t;

	// raw instruction word from memory
	typedef logic [31:0] insn_t;

	// index into the fetch buffer
	typedef logic [`FE_IFB_PTR_W-1:0] ifb_ptr_t;

	// occupancy, one bit wider so a full buffer fits
	typedef logic [`FE_IFB_PTR_W:0] ifb_cnt_t;

endpackage

//--- common/fe_ctrl_pkg.sv
package fe_ctrl_pkg;

	// fetch controller states
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		STALL
	} fetch_state_e;

endpackage

//--- ifb/ifb_ram.sv
`timescale 1ns/1ps
`include "fe_cfg.svh"

module ifb_ram (
	input  logic                   clk,
	input  logic                   wr_en_i,
	input  fe_types_pkg::ifb_ptr_t wr_ptr_i,
	input  fe_types_pkg::pc_t      wr_pc_i,
	input  fe_types_pkg::insn_t    wr_insn_i,
	input  fe_types_pkg::ifb_ptr_t rd_ptr_i,
	output fe_types_pkg::pc_t      rd_pc_o,
	output fe_types_pkg::insn_t    rd_insn_o
);
	import fe_types_pkg::*;

	// one pc and one instruction per buffer slot
	pc_t   pc_mem   [`FE_IFB_DEPTH];
	insn_t insn_mem [`FE_IFB_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			pc_mem[wr_ptr_i]   <= wr_pc_i;
			insn_mem[wr_ptr_i] <= wr_insn_i;
		end
	end

	// head entry visible without a clock
	assign rd_pc_o   = pc_mem[rd_ptr_i];
	assign rd_insn_o = insn_mem[rd_ptr_i];

endmodule

//--- ifb/ifb.sv
`timescale 1ns/1ps

module ifb (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   flush_i,
	input  logic                   wr_valid_i,
	input  fe_types_pkg::pc_t      wr_pc_i,
	input  fe_types_pkg::insn_t    wr_insn_i,
	input  logic                   pop_i,
	output fe_types_pkg::ifb_cnt_t count_o,
	output logic                   full_o,
	output logic                   valid_o,
	output fe_types_pkg::pc_t      pc_o,
	output fe_types_pkg::insn_t    insn_o
);
	import fe_types_pkg::*;

	ifb_ptr_t head_q;
	ifb_ptr_t tail_q;
	logic     head_wrap_q;
	logic     tail_wrap_q;

	pc_t   rd_pc;
	insn_t rd_insn;

	logic empty;
	logic full;
	logic bypass;
	logic wr_en;
	logic rd_pop;

	// same index, wrap bits tell empty from full
	assign empty = (head_q == tail_q) && (head_wrap_q == tail_wrap_q);
	assign full  = (head_q == tail_q) && (head_wrap_q != tail_wrap_q);

	// wrap bit as msb makes the difference the occupancy
	assign count_o = {tail_wrap_q, tail_q} - {head_wrap_q, head_q};
	assign full_o  = full;

	// empty buffer hands the arriving word straight to decode
	assign bypass = empty && wr_valid_i;

	// redirect hides the output for the whole cycle
	assign valid_o = !flush_i && (!empty || wr_valid_i);
	assign pc_o    = bypass ? wr_pc_i : rd_pc;
	assign insn_o  = bypass ? wr_insn_i : rd_insn;

	assign rd_pop = pop_i && !flush_i && !empty;

	// a bypassed word taken by decode this cycle is never stored
	assign wr_en = wr_valid_i && !flush_i && (!full || rd_pop) && !(bypass && pop_i);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			head_q      <= '0;
			tail_q      <= '0;
			head_wrap_q <= 1'b0;
			tail_wrap_q <= 1'b0;
		end else if (flush_i) begin
			head_q      <= '0;
			tail_q      <= '0;
			head_wrap_q <= 1'b0;
			tail_wrap_q <= 1'b0;
		end else begin
			// carry out of the index flips the wrap bit
			if (wr_en) begin
				{tail_wrap_q, tail_q} <= {tail_wrap_q, tail_q} + 1'b1;
			end
			if (rd_pop) begin
				{head_wrap_q, head_q} <= {head_wrap_q, head_q} + 1'b1;
			end
		end
	end

	ifb_ram u_ram (
		.clk       (clk),
		.wr_en_i   (wr_en),
		.wr_ptr_i  (tail_q),
		.wr_pc_i   (wr_pc_i),
		.wr_insn_i (wr_insn_i),
		.rd_ptr_i  (head_q),
		.rd_pc_o   (rd_pc),
		.rd_insn_o (rd_insn)
	);

endmodule

//--- source/fetch_ctrl.sv
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fetch_ctrl (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   redirect_i,
	input  fe_types_pkg::ifb_cnt_t ifb_count_i,
	output logic                   fetch_en_o,
	output logic                   resp_accept_o
);
	import fe_ctrl_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;

	// request issued last cycle, its response shows up this cycle
	logic req_q;
	// that response belongs to a path a redirect already left
	logic discard_q;
	logic inflight;
	logic [`FE_IFB_PTR_W+1:0] need;
	logic room;

	// a discarded response never takes a buffer slot
	assign inflight = req_q && !discard_q;

	// slots taken once the response now in flight has landed
	assign need = {1'b0, ifb_count_i} + {{(`FE_IFB_PTR_W+1){1'b0}}, inflight};

	// a new request is only safe if its response finds a free slot
	assign room = need < `FE_IFB_DEPTH;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				state_d = FETCH;
			end
			FETCH: begin
				if (!room) begin
					state_d = STALL;
				end
			end
			STALL: begin
				if (room) begin
					state_d = FETCH;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// no request in the cycle leaving reset
	assign fetch_en_o = (state_q != IDLE) && (state_d == FETCH);

	assign resp_accept_o = !discard_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= IDLE;
			req_q     <= 1'b0;
			discard_q <= 1'b0;
		end else begin
			state_q   <= state_d;
			req_q     <= fetch_en_o;
			// request sent alongside a redirect fetches the old path
			discard_q <= redirect_i && fetch_en_o;
		end
	end

endmodule

//--- source/pc_gen.sv
`timescale 1ns/1ps
`include "fe_cfg.svh"

module pc_gen (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              fetch_en_i,
	input  logic              redirect_i,
	input  fe_types_pkg::pc_t redirect_pc_i,
	output fe_types_pkg::pc_t req_pc_o,
	output fe_types_pkg::pc_t resp_pc_o
);
	import fe_types_pkg::*;

	// address of the next request
	pc_t pc_q;
	// address of the request one cycle back, tags the response
	pc_t resp_pc_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= `FE_PC_RESET;
		end else if (redirect_i) begin
			pc_q <= redirect_pc_i;
		end else if (fetch_en_i) begin
			pc_q <= pc_q + 64'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_en_i) begin
			resp_pc_q <= pc_q;
		end
	end

	assign req_pc_o  = pc_q;
	assign resp_pc_o = resp_pc_q;

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                redirect_i,
	input  fe_types_pkg::pc_t   redirect_pc_i,
	output logic                fetch_req_o,
	output fe_types_pkg::pc_t   fetch_pc_o,
	input  logic                insn_valid_i,
	input  fe_types_pkg::insn_t insn_i,
	input  logic                pop_i,
	output logic                ifb_valid_o,
	output fe_types_pkg::pc_t   ifb_pc_o,
	output fe_types_pkg::insn_t ifb_insn_o,
	output logic                ifb_full_o
);
	import fe_types_pkg::*;

	logic     fetch_en;
	logic     resp_accept;
	logic     wr_valid;
	pc_t      req_pc;
	pc_t      resp_pc;
	ifb_cnt_t ifb_count;

	assign fetch_req_o = fetch_en;
	assign fetch_pc_o  = req_pc;

	// responses from before a redirect are dropped here
	assign wr_valid = insn_valid_i && resp_accept;

	fetch_ctrl u_ctrl (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.redirect_i    (redirect_i),
		.ifb_count_i   (ifb_count),
		.fetch_en_o    (fetch_en),
		.resp_accept_o (resp_accept)
	);

	pc_gen u_pc_gen (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.fetch_en_i    (fetch_en),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.req_pc_o      (req_pc),
		.resp_pc_o     (resp_pc)
	);

	ifb u_ifb (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.flush_i    (redirect_i),
		.wr_valid_i (wr_valid),
		.wr_pc_i    (resp_pc),
		.wr_insn_i  (insn_i),
		.pop_i      (pop_i),
		.count_o    (ifb_count),
		.full_o     (ifb_full_o),
		.valid_o    (ifb_valid_o),
		.pc_o       (ifb_pc_o),
		.insn_o     (ifb_insn_o)
	);

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int half_period_ns = 50,
	parameter int reset_cycles   = 2
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(half_period_ns) clk_o = ~clk_o;
		end
	end

	// release lands on a falling edge, away from the active edge
	initial begin
		arst_n_o = 1'b0;
		#(2 * half_period_ns * reset_cycles);
		arst_n_o = 1'b1;
	end

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fetch_tb;
	import fe_types_pkg::*;

	localparam int period_ns     = 100;
	localparam int num_cases     = 17;
	localparam int case_fields   = 6;
	localparam int margin_cycles = 64;
	localparam insn_t insn_key   = 32'hdeadbeef;

	logic  clk;
	logic  arst_n;
	logic  redirect;
	pc_t   redirect_pc;
	logic  fetch_req;
	pc_t   fetch_pc;
	logic  insn_valid;
	insn_t insn;
	logic  pop;
	logic  ifb_valid;
	pc_t   ifb_pc;
	insn_t ifb_insn;
	logic  ifb_full;

	// cycles, pop weight, redirect, target, check, head pc per row
	logic [63:0] case_mem [num_cases * case_fields];

	// pcs of the current path requested but not yet delivered
	pc_t  exp_q [$];
	pc_t  exp_fetch_pc = `FE_PC_RESET;
	logic exp_inflight = 1'b0;

	// memory response scheduled for the next cycle
	logic  mem_valid_nx = 1'b0;
	insn_t mem_insn_nx  = '0;

	int unsigned watchdog_cycles = 0;
	int unsigned delivered       = 0;

	tb_clk_gen #(
		.half_period_ns (period_ns / 2),
		.reset_cycles   (2)
	) u_clk_gen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	fetch_top u_dut (
		.clk           (clk),
		.arst_n_i      (arst_n),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.fetch_req_o   (fetch_req),
		.fetch_pc_o    (fetch_pc),
		.insn_valid_i  (insn_valid),
		.insn_i        (insn),
		.pop_i         (pop),
		.ifb_valid_o   (ifb_valid),
		.ifb_pc_o      (ifb_pc),
		.ifb_insn_o    (ifb_insn),
		.ifb_full_o    (ifb_full)
	);

	// instruction memory contents as a function of the address
	function automatic insn_t mem_word(input pc_t pc);
		return pc[31:0] ^ insn_key;
	endfunction

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "run stopped on the first failure");
	endtask

	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_insn(input string name, input insn_t got, input insn_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic load_cases();
		int unsigned total;
		total = margin_cycles;
		$readmemh("verif/fetch_cases.txt", case_mem);
		for (int i = 0; i < num_cases; i++) begin
			if ($isunknown(case_mem[i * case_fields]) || case_mem[i * case_fields] == '0) begin
				$display("case %0d in the case file has no cycle count", i);
				abort_run();
			end
			total += case_mem[i * case_fields][31:0];
		end
		watchdog_cycles = total;
	endtask

	task automatic drive_cycle(input logic redir, input pc_t target, input logic [8:0] weight);
		logic pop_nx;
		pop_nx = {23'd0, weight} > ($urandom % 256);
		@(posedge clk);
		redirect    <= redir;
		redirect_pc <= redir ? target : '0;
		pop         <= pop_nx;
		insn_valid  <= mem_valid_nx;
		insn        <= mem_insn_nx;
	endtask

	task automatic observe_cycle();
		int   held;
		logic exp_req;
		logic exp_full;
		logic exp_valid;
		@(negedge clk);
		held      = exp_q.size();
		// room needed for the response already in flight
		exp_req   = held < `FE_IFB_DEPTH;
		exp_full  = (held - (exp_inflight ? 1 : 0)) == `FE_IFB_DEPTH;
		exp_valid = !redirect && held != 0;
		check_flag("fetch_req_o", fetch_req, exp_req);
		check_flag("ifb_full_o", ifb_full, exp_full);
		check_flag("ifb_valid_o", ifb_valid, exp_valid);
		if (exp_valid) begin
			check_pc("ifb_pc_o", ifb_pc, exp_q[0]);
			check_insn("ifb_insn_o", ifb_insn, mem_word(exp_q[0]));
		end
		if (fetch_req) begin
			check_pc("fetch_pc_o", fetch_pc, exp_fetch_pc);
		end
		mem_valid_nx = fetch_req;
		mem_insn_nx  = fetch_req ? mem_word(fetch_pc) : '0;
		if (redirect) begin
			// drop the old path and any request sent this cycle
			exp_q.delete();
			exp_fetch_pc = redirect_pc;
			exp_inflight = 1'b0;
		end else begin
			if (pop && exp_valid) begin
				exp_q.delete(0);
				delivered++;
			end
			if (fetch_req) begin
				exp_q.push_back(exp_fetch_pc);
				exp_fetch_pc += 64'd4;
			end
			exp_inflight = fetch_req;
		end
	endtask

	task automatic run_case(input int idx);
		int unsigned cycles;
		logic [8:0]  weight;
		logic        do_redirect;
		pc_t         target;
		logic        do_check;
		pc_t         head_pc;
		cycles      = case_mem[idx * case_fields][31:0];
		weight      = case_mem[idx * case_fields + 1][8:0];
		do_redirect = case_mem[idx * case_fields + 2][0];
		target      = case_mem[idx * case_fields + 3];
		do_check    = case_mem[idx * case_fields + 4][0];
		head_pc     = case_mem[idx * case_fields + 5];
		// redirect only in the first cycle of a case
		for (int unsigned c = 0; c < cycles; c++) begin
			drive_cycle(do_redirect && c == 0, target, weight);
			observe_cycle();
		end
		if (do_check) begin
			check_flag("ifb_valid_o", ifb_valid, 1'b1);
			check_pc("ifb_pc_o", ifb_pc, head_pc);
		end
	endtask

	initial begin
		wait (watchdog_cycles != 0);
		#(watchdog_cycles * period_ns);
		$display("watchdog expired after %0d cycles without the run ending", watchdog_cycles);
		abort_run();
	end

	initial begin
		redirect    = 1'b0;
		redirect_pc = '0;
		insn_valid  = 1'b0;
		insn        = '0;
		pop         = 1'b0;
		void'($urandom(32'hf0186e9c));
		load_cases();

		// outputs quiet while reset is held
		@(negedge clk);
		check_flag("fetch_req_o", fetch_req, 1'b0);
		check_flag("ifb_valid_o", ifb_valid, 1'b0);
		check_flag("ifb_full_o", ifb_full, 1'b0);

		// still idle in the cycle of release
		@(posedge arst_n);
		check_flag("fetch_req_o", fetch_req, 1'b0);

		for (int i = 0; i < num_cases; i++) begin
			run_case(i);
		end

		$display("delivered %0d instructions over %0d cases", delivered, num_cases);
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- verif/fetch_cases.txt
// row fields in hex: cycles, pop weight, redirect flag, redirect target, check flag, head pc
// pop weight 100 pops every cycle, 0 never pops; head pc is checked in the last cycle

// straight line with decode always ready, bypass path
14 100 0 0000000000000000 1 0000000000001048

// withhold pops until full and stalled
0c 000 0 0000000000000000 1 000000000000104c

// resume pops, nothing lost
06 100 0 0000000000000000 1 0000000000001060

// redirect with a partly full buffer
04 000 1 0000000000002000 1 0000000000002000
08 100 0 0000000000000000 1 000000000000201c

// redirect while draining
03 100 1 0000000000003000 1 0000000000003000

// back to back redirects
01 100 1 0000000000004000 0 0000000000000000
01 100 1 0000000000005000 0 0000000000000000
02 100 0 0000000000000000 1 0000000000005000

// fill again, then redirect while stalled
0c 000 0 0000000000000000 1 0000000000005004
03 000 1 0000000000006000 1 0000000000006000

// random pops and redirects, pointers wrap many times
c8 080 0 0000000000000000 0 0000000000000000
96 0a0 1 0000000000007ff0 0 0000000000000000
64 040 1 fffffffffffffff0 0 0000000000000000
12c 0c0 1 0000000000123450 0 0000000000000000

// known state again after random traffic
03 100 1 0000000000008000 1 0000000000008000
0a 100 0 0000000000000000 1 0000000000008028

//--- src.f
+incdir+common
common/fe_types_pkg.sv
common/fe_ctrl_pkg.sv
ifb/ifb_ram.sv
ifb/ifb.sv
source/fetch_ctrl.sv
source/pc_gen.sv
source/fetch_top.sv
verif/tb_clk_gen.sv
verif/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j $(JOBS)

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

# the simulator exit status decides pass or fail
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
